// File: Makefile
TOP   ?= tb_mem_sys
LOG   ?= sim.log
OBJ   ?= obj_dir
FLAGS ?= --binary --timing -j 0
FLIST := sim.f

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "make clean  remove the build folder and the log"

test:
	verilator $(FLAGS) --top-module $(TOP) -Mdir $(OBJ) -f $(FLIST)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: cache_pkg.sv
package cache_pkg;

  // Address split, 16-bit byte address
  localparam int TAG_W    = 6;
  localparam int INDEX_W  = 6;
  localparam int OFFSET_W = 3;

  // Bit 0 ignored, words are even aligned
  localparam int OFFSET_LSB = 1;
  localparam int INDEX_LSB  = OFFSET_LSB + OFFSET_W;
  localparam int TAG_LSB    = INDEX_LSB + INDEX_W;

  localparam int NUM_BLOCKS      = 2 ** INDEX_W;
  localparam int WORDS_PER_BLOCK = 2 ** OFFSET_W;

  // Main memory read latency in cycles
  localparam int MEM_LATENCY_DEFAULT = 4;

  typedef logic [15:0] word_t;
  typedef logic [15:0] addr_t;

  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  // Instruction fetch request
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  // Load or store request
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
  } data_req_t;

  // Response, data only meaningful for fetch and load
  typedef struct packed {
    logic  valid;
    word_t data;
  } rsp_t;

  // Cache write port, fills and stores
  typedef struct packed {
    logic  en;
    logic  tag_write;
    addr_t addr;
    word_t data;
  } cache_wr_t;

  function automatic tag_t addr_tag(addr_t a);
    return a[TAG_LSB +: TAG_W];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[INDEX_LSB +: INDEX_W];
  endfunction

  function automatic offset_t addr_offset(addr_t a);
    return a[OFFSET_LSB +: OFFSET_W];
  endfunction

  // Rebuild an even byte address from its fields
  function automatic addr_t make_addr(tag_t t, index_t i, offset_t o);
    return {t, i, o, 1'b0};
  endfunction

endpackage

// File: cache_way.sv
`timescale 1ns/1ps

module cache_way (
  input  logic             clk,
  input  logic             reset,
  input  cache_pkg::addr_t lookup_addr,
  output logic             hit,
  output cache_pkg::word_t rdata,
  input  logic             write_en,
  input  logic             tag_write,
  input  cache_pkg::addr_t write_addr,
  input  cache_pkg::word_t write_data
);

  localparam int NUM_WORDS = cache_pkg::NUM_BLOCKS * cache_pkg::WORDS_PER_BLOCK;

  logic [cache_pkg::NUM_BLOCKS-1:0] valid_bits;
  cache_pkg::tag_t                  tag_arr  [cache_pkg::NUM_BLOCKS];
  cache_pkg::word_t                 data_arr [NUM_WORDS];

  cache_pkg::tag_t    lk_tag;
  cache_pkg::index_t  lk_index;
  cache_pkg::offset_t lk_offset;
  cache_pkg::tag_t    wr_tag;
  cache_pkg::index_t  wr_index;
  cache_pkg::offset_t wr_offset;

  // Field split for both ports
  assign lk_tag    = cache_pkg::addr_tag(lookup_addr);
  assign lk_index  = cache_pkg::addr_index(lookup_addr);
  assign lk_offset = cache_pkg::addr_offset(lookup_addr);
  assign wr_tag    = cache_pkg::addr_tag(write_addr);
  assign wr_index  = cache_pkg::addr_index(write_addr);
  assign wr_offset = cache_pkg::addr_offset(write_addr);

  // Combinational lookup
  assign hit   = valid_bits[lk_index] && (tag_arr[lk_index] == lk_tag);
  assign rdata = data_arr[{lk_index, lk_offset}];

  // Valid set with the last word of a fill
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
    end else if (write_en && tag_write) begin
      valid_bits[wr_index] <= 1'b1;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    if (write_en) begin
      data_arr[{wr_index, wr_offset}] <= write_data;
      if (tag_write) begin
        tag_arr[wr_index] <= wr_tag;
      end
    end
  end

endmodule

// File: fill_ctrl.sv
`timescale 1ns/1ps

module fill_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::fetch_req_t  fetch_pend,
  input  cache_pkg::data_req_t   data_pend,
  output logic                   fetch_done,
  output logic                   data_done,
  output cache_pkg::rsp_t        fetch_rsp,
  output cache_pkg::rsp_t        data_rsp,
  input  logic                   i_hit,
  input  logic                   d_hit,
  input  cache_pkg::word_t       i_rdata,
  input  cache_pkg::word_t       d_rdata,
  output cache_pkg::cache_wr_t   i_wr,
  output cache_pkg::cache_wr_t   d_wr,
  output logic                   rd_en,
  output logic                   wr_en,
  output cache_pkg::addr_t       mem_addr,
  output cache_pkg::word_t       mem_wdata,
  input  logic                   rd_valid,
  input  cache_pkg::word_t       rd_data
);

  localparam cache_pkg::offset_t LAST_WORD =
    cache_pkg::offset_t'(cache_pkg::WORDS_PER_BLOCK - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT
  } state_t;

  state_t             state;
  logic               fill_dside;
  cache_pkg::addr_t   fill_base;
  cache_pkg::offset_t issue_cnt;
  cache_pkg::offset_t ret_cnt;

  logic                 i_miss;
  logic                 d_miss;
  logic                 store_hit;
  logic                 fill_ret;
  logic                 last_ret;
  cache_pkg::tag_t      fill_tag;
  cache_pkg::index_t    fill_index;
  cache_pkg::cache_wr_t fill_wr;

  // Lookups only count while idle
  assign i_miss = (state == ST_IDLE) && fetch_pend.valid && !i_hit;
  assign d_miss = (state == ST_IDLE) && data_pend.valid && !d_hit;

  // Hits answered in idle, both ports at once
  assign fetch_done = (state == ST_IDLE) && fetch_pend.valid && i_hit;
  assign data_done  = (state == ST_IDLE) && data_pend.valid && d_hit;
  assign store_hit  = data_done && data_pend.write;

  // Block under fill
  assign fill_tag   = cache_pkg::addr_tag(fill_base);
  assign fill_index = cache_pkg::addr_index(fill_base);
  assign fill_ret   = (state != ST_IDLE) && rd_valid;
  assign last_ret   = fill_ret && (ret_cnt == LAST_WORD);

  // Returning word, tag goes in with the last one
  always_comb begin
    fill_wr           = '0;
    fill_wr.en        = fill_ret;
    fill_wr.tag_write = last_ret;
    fill_wr.addr      = cache_pkg::make_addr(fill_tag, fill_index, ret_cnt);
    fill_wr.data      = rd_data;
  end

  // Write ports of both caches
  always_comb begin
    i_wr = '0;
    d_wr = '0;
    if (!fill_dside) begin
      i_wr = fill_wr;
    end else begin
      d_wr = fill_wr;
    end
    // Store hit updates the cached word, only while idle
    if (store_hit) begin
      d_wr.en   = 1'b1;
      d_wr.addr = data_pend.addr;
      d_wr.data = data_pend.wdata;
    end
  end

  // Block reads while issuing, write-through on a store hit
  assign rd_en     = (state == ST_ISSUE);
  assign wr_en     = store_hit;
  assign mem_addr  = rd_en ? cache_pkg::make_addr(fill_tag, fill_index, issue_cnt)
                           : data_pend.addr;
  assign mem_wdata = data_pend.wdata;

  // Miss arbitration and fill sequencing
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      fill_dside <= 1'b0;
      fill_base  <= '0;
      issue_cnt  <= '0;
      ret_cnt    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          issue_cnt <= '0;
          ret_cnt   <= '0;
          // Data miss first
          if (d_miss) begin
            fill_dside <= 1'b1;
            fill_base  <= data_pend.addr;
            state      <= ST_ISSUE;
          end else if (i_miss) begin
            fill_dside <= 1'b0;
            fill_base  <= fetch_pend.addr;
            state      <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          issue_cnt <= issue_cnt + 1'b1;
          if (issue_cnt == LAST_WORD) begin
            state <= ST_WAIT;
          end
        end
        default: begin
          // Replay the lookup once the block is complete
          if (last_ret) begin
            state <= ST_IDLE;
          end
        end
      endcase
      // Returns may overlap the issue phase
      if (fill_ret) begin
        ret_cnt <= ret_cnt + 1'b1;
      end
    end
  end

  // Registered responses, one cycle after done
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_rsp <= '0;
      data_rsp  <= '0;
    end else begin
      fetch_rsp.valid <= fetch_done;
      fetch_rsp.data  <= i_rdata;
      data_rsp.valid  <= data_done;
      data_rsp.data   <= d_rdata;
    end
  end

endmodule

// File: main_mem.sv
`timescale 1ns/1ps

module main_mem #(
  parameter int mem_latency = cache_pkg::MEM_LATENCY_DEFAULT
) (
  input  logic             clk,
  input  logic             rd_en,
  input  logic             wr_en,
  input  cache_pkg::addr_t mem_addr,
  input  cache_pkg::word_t wdata,
  output logic             rd_valid,
  output cache_pkg::word_t rd_data
);

  // Word addressed, byte address bit 0 dropped
  localparam int MEM_WORDS = 2 ** ($bits(cache_pkg::addr_t) - 1);

  cache_pkg::word_t mem [MEM_WORDS];

  // Read pipeline, one stage per cycle of latency
  logic [mem_latency-1:0] vld_pipe = '0;
  cache_pkg::word_t       data_pipe [mem_latency];

  // Contents start at zero
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[mem_addr[15:1]] <= wdata;
    end
  end

  // A new read may enter every cycle
  always_ff @(posedge clk) begin
    vld_pipe[0]  <= rd_en;
    data_pipe[0] <= mem[mem_addr[15:1]];
    for (int i = 1; i < mem_latency; i++) begin
      vld_pipe[i]  <= vld_pipe[i-1];
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  assign rd_valid = vld_pipe[mem_latency-1];
  assign rd_data  = data_pipe[mem_latency-1];

endmodule

// File: mem_sys_cases.txt
# op addr data addr2 data2, all hex; op is F fetch, L load, S store, B fetch and load
# data is the store value or the expected word; addr2 and data2 are the load of a B case
L 0040 0000 0000 0000
S 0040 1234 0000 0000
L 0040 1234 0000 0000
S 0852 abcd 0000 0000
L 0852 abcd 0000 0000
F 0852 abcd 0000 0000
S 0054 5555 0000 0000
L 0852 abcd 0000 0000
L 0054 5555 0000 0000
L 0852 abcd 0000 0000
S 0046 1111 0000 0000
L 0042 0000 0000 0000
L 0046 1111 0000 0000
L 004e 0000 0000 0000
F 0040 1234 0000 0000
F 0046 1111 0000 0000
B 0100 0000 0200 0000
S 0a30 beef 0000 0000
S 1330 cafe 0000 0000
S 1730 0f0f 0000 0000
B 0a30 beef 1330 cafe
L 1730 0f0f 0000 0000

// File: mem_sys_top.sv
`timescale 1ns/1ps

module mem_sys_top #(
  parameter int mem_latency = cache_pkg::MEM_LATENCY_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_pkg::fetch_req_t fetch_req,
  output cache_pkg::rsp_t       fetch_rsp,
  output logic                  fetch_credit,
  input  cache_pkg::data_req_t  data_req,
  output cache_pkg::rsp_t       data_rsp,
  output logic                  data_credit
);

  cache_pkg::fetch_req_t fetch_pend;
  cache_pkg::data_req_t  data_pend;
  logic                  fetch_done;
  logic                  data_done;

  logic                  i_hit;
  logic                  d_hit;
  cache_pkg::word_t      i_rdata;
  cache_pkg::word_t      d_rdata;
  cache_pkg::cache_wr_t  i_wr;
  cache_pkg::cache_wr_t  d_wr;

  logic                  rd_en;
  logic                  wr_en;
  cache_pkg::addr_t      mem_addr;
  cache_pkg::word_t      mem_wdata;
  logic                  rd_valid;
  cache_pkg::word_t      rd_data;

  // Request slots, one credit each
  req_slot #(.req_t(cache_pkg::fetch_req_t)) fetch_slot (
    .clk     (clk),
    .reset   (reset),
    .req     (fetch_req),
    .done    (fetch_done),
    .pending (fetch_pend),
    .credit  (fetch_credit)
  );

  req_slot #(.req_t(cache_pkg::data_req_t)) data_slot (
    .clk     (clk),
    .reset   (reset),
    .req     (data_req),
    .done    (data_done),
    .pending (data_pend),
    .credit  (data_credit)
  );

  // Instruction cache looks up the pending fetch
  cache_way icache (
    .clk         (clk),
    .reset       (reset),
    .lookup_addr (fetch_pend.addr),
    .hit         (i_hit),
    .rdata       (i_rdata),
    .write_en    (i_wr.en),
    .tag_write   (i_wr.tag_write),
    .write_addr  (i_wr.addr),
    .write_data  (i_wr.data)
  );

  // Data cache looks up the pending load or store
  cache_way dcache (
    .clk         (clk),
    .reset       (reset),
    .lookup_addr (data_pend.addr),
    .hit         (d_hit),
    .rdata       (d_rdata),
    .write_en    (d_wr.en),
    .tag_write   (d_wr.tag_write),
    .write_addr  (d_wr.addr),
    .write_data  (d_wr.data)
  );

  fill_ctrl ctrl (
    .clk        (clk),
    .reset      (reset),
    .fetch_pend (fetch_pend),
    .data_pend  (data_pend),
    .fetch_done (fetch_done),
    .data_done  (data_done),
    .fetch_rsp  (fetch_rsp),
    .data_rsp   (data_rsp),
    .i_hit      (i_hit),
    .d_hit      (d_hit),
    .i_rdata    (i_rdata),
    .d_rdata    (d_rdata),
    .i_wr       (i_wr),
    .d_wr       (d_wr),
    .rd_en      (rd_en),
    .wr_en      (wr_en),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data)
  );

  // Shared backing store
  main_mem #(.mem_latency(mem_latency)) mem (
    .clk      (clk),
    .rd_en    (rd_en),
    .wr_en    (wr_en),
    .mem_addr (mem_addr),
    .wdata    (mem_wdata),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

endmodule

// File: req_slot.sv
`timescale 1ns/1ps

module req_slot #(
  parameter type req_t = cache_pkg::fetch_req_t
) (
  input  logic clk,
  input  logic reset,
  input  req_t req,
  input  logic done,
  output req_t pending,
  output logic credit
);

  // One request per port, held until the controller serves it
  always_ff @(posedge clk) begin
    if (reset) begin
      pending.valid <= 1'b0;
    end else if (req.valid) begin
      // Requester only sends while holding the credit
      pending <= req;
    end else if (done) begin
      pending.valid <= 1'b0;
    end
  end

  // Credit goes back in the same cycle as the registered response
  always_ff @(posedge clk) begin
    if (reset) begin
      credit <= 1'b0;
    end else begin
      credit <= done;
    end
  end

endmodule

// File: sim.f
cache_pkg.sv
req_slot.sv
cache_way.sv
main_mem.sv
fill_ctrl.sv
mem_sys_top.sv
tb_mem_sys.sv

// File: tb_mem_sys.sv
`timescale 1ns/1ps

module tb_mem_sys;

  logic                  clk = 1'b0;
  logic                  reset;
  cache_pkg::fetch_req_t fetch_req;
  cache_pkg::rsp_t       fetch_rsp;
  logic                  fetch_credit;
  cache_pkg::data_req_t  data_req;
  cache_pkg::rsp_t       data_rsp;
  logic                  data_credit;

  // Case table from the data file
  logic [7:0]       op_q    [$];
  cache_pkg::addr_t addr_q  [$];
  cache_pkg::word_t word_q  [$];
  cache_pkg::addr_t addr2_q [$];
  cache_pkg::word_t word2_q [$];

  // Issued and answered counts, one credit per port
  int               f_iss = 0;
  int               f_ret = 0;
  int               d_iss = 0;
  int               d_ret = 0;
  cache_pkg::word_t f_data;
  cache_pkg::word_t d_data;

  int         val_errs = 0;
  int         proto_errs = 0;
  int         cycles = 0;
  int         limit = 0;
  logic [7:0] lfsr = 8'd29;
  logic       started = 1'b0;

  mem_sys_top uut (
    .clk          (clk),
    .reset        (reset),
    .fetch_req    (fetch_req),
    .fetch_rsp    (fetch_rsp),
    .fetch_credit (fetch_credit),
    .data_req     (data_req),
    .data_rsp     (data_rsp),
    .data_credit  (data_credit)
  );

  always #5 clk = ~clk;

  // Galois LFSR, taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  // Idle gap of 0 to 3 cycles, one step per bit
  task automatic take_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      gap = (gap * 2) + int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic load_cases(output bit ok);
    int               fd;
    int               n;
    string            line;
    logic [7:0]       op;
    cache_pkg::addr_t a;
    cache_pkg::addr_t a2;
    cache_pkg::word_t d;
    cache_pkg::word_t d2;
    fd = $fopen("mem_sys_cases.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%c %h %h %h %h", op, a, d, a2, d2);
        // Comment lines stop after the first field
        if (n == 5 && op != "#") begin
          op_q.push_back(op);
          addr_q.push_back(a);
          word_q.push_back(d);
          addr2_q.push_back(a2);
          word2_q.push_back(d2);
        end
      end
      $fclose(fd);
    end
    ok = (fd != 0) && (op_q.size() > 0);
  endtask

  task automatic check_word(input string name, input cache_pkg::word_t exp,
                            input cache_pkg::word_t got);
    assert (got === exp)
      else begin
        $display("ERR %s expected %h actual %h", name, exp, got);
        val_errs++;
      end
  endtask

  task automatic run_case(input int n);
    logic [7:0] op;
    string      name;
    int         gap;
    int         f_base;
    int         d_base;
    bit         use_f;
    bit         use_d;
    op = op_q[n];
    name = $sformatf("case%0d_%c_%h", n, op, addr_q[n]);
    use_f = (op == "F") || (op == "B");
    use_d = (op == "L") || (op == "S") || (op == "B");
    take_gap(gap);
    repeat (gap) @(posedge clk);
    // Issue only while holding the credit
    while (f_iss != f_ret || d_iss != d_ret) @(posedge clk);
    f_base = f_ret;
    d_base = d_ret;
    if (use_f) begin
      fetch_req <= '{valid: 1'b1, addr: addr_q[n]};
      f_iss <= f_iss + 1;
    end
    if (op == "B") begin
      data_req <= '{valid: 1'b1, write: 1'b0, addr: addr2_q[n], wdata: '0};
    end else if (use_d) begin
      data_req <= '{valid: 1'b1, write: (op == "S"), addr: addr_q[n], wdata: word_q[n]};
    end
    if (use_d) begin
      d_iss <= d_iss + 1;
    end
    @(posedge clk);
    fetch_req.valid <= 1'b0;
    data_req.valid <= 1'b0;
    // Response marks the end, timeout guards a hang
    while ((use_f && f_ret == f_base) || (use_d && d_ret == d_base)) @(posedge clk);
    if (use_f) begin
      check_word(name, word_q[n], f_data);
    end
    if (op == "B") begin
      check_word({name, "_load"}, word2_q[n], d_data);
    end else if (op == "L") begin
      check_word(name, word_q[n], d_data);
    end
  endtask

  // Response monitor, credit travels with every response
  always @(posedge clk) begin
    if (started) begin
      assert (fetch_credit === fetch_rsp.valid)
        else begin
          $display("fetch credit and fetch response out of step at cycle %0d", cycles);
          proto_errs++;
        end
      assert (data_credit === data_rsp.valid)
        else begin
          $display("data credit and data response out of step at cycle %0d", cycles);
          proto_errs++;
        end
      if (fetch_rsp.valid === 1'b1) begin
        assert (f_iss != f_ret)
          else begin
            $display("fetch response with no request outstanding at cycle %0d", cycles);
            proto_errs++;
          end
        f_ret <= f_ret + 1;
        f_data <= fetch_rsp.data;
      end
      if (data_rsp.valid === 1'b1) begin
        assert (d_iss != d_ret)
          else begin
            $display("data response with no request outstanding at cycle %0d", cycles);
            proto_errs++;
          end
        d_ret <= d_ret + 1;
        d_data <= data_rsp.data;
      end
    end
    started <= 1'b1;
  end

  // Run limit from the case count
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout, run did not finish within %0d cycles", limit);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    bit ok;
    reset = 1'b1;
    fetch_req = '0;
    data_req = '0;
    load_cases(ok);
    if (!ok) begin
      $display("could not read any case from mem_sys_cases.txt");
      $display("TB FAILED");
      $finish;
    end else begin
      limit = 16 + 40 * op_q.size();
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      for (int n = 0; n < op_q.size(); n++) begin
        run_case(n);
      end
      // A few more cycles to catch a stray response
      repeat (4) @(posedge clk);
      $display("%0d cases, %0d value errors, %0d protocol errors",
               op_q.size(), val_errs, proto_errs);
      if (val_errs == 0 && proto_errs == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

endmodule
